// File: hdl/mac_mgmt_pkg.sv
/*
 * Shared definitions for the MAC cluster management block.
 * Widths, bus structs, MDIO command layout and register offsets used by
 * the allocator, the core register slices and the MDIO transmitter.
 * Import with a wildcard in the module header.
 */
package mac_mgmt_pkg;

    ////////////////////
    // Sizes and timing
    ////////////////////
    localparam int N_CORES       = 4;
    localparam int CORE_SEL_W    = $clog2(N_CORES);
    localparam int APB_ADDR_W    = 21;
    localparam int CORE_ADDR_W   = 19;
    localparam int APB_DATA_W    = 32;
    localparam int MDIO_DATA_W   = 16;
    localparam int MDIO_ADDR_W   = 5;
    localparam int MDC_HALF      = 4;
    localparam int MDC_DIV_W     = $clog2(MDC_HALF);
    localparam int FRAME_BITS    = 64;
    localparam int BIT_CNT_W     = $clog2(FRAME_BITS);
    // Bit positions inside a frame, counted from the first preamble bit
    localparam int MDIO_TA_POS   = 46;
    localparam int MDIO_DATA_POS = 48;

    typedef logic [APB_ADDR_W-1:0]  apb_addr_t;
    typedef logic [CORE_ADDR_W-1:0] core_addr_t;
    typedef logic [APB_DATA_W-1:0]  apb_data_t;
    typedef logic [MDIO_DATA_W-1:0] mdio_data_t;
    typedef logic [MDIO_ADDR_W-1:0] mdio_addr_t;
    typedef logic [CORE_SEL_W-1:0]  core_idx_t;
    typedef logic [FRAME_BITS-1:0]  mdio_frame_t;
    typedef logic [3:0]             reg_off_t;

    typedef enum logic [1:0] {
        OP_WRITE = 2'b01,
        OP_READ  = 2'b10
    } mdio_op_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SHIFT,
        ST_DONE
    } mdio_state_t;

    ////////////////////
    // Bus structs
    ////////////////////
    typedef struct packed {
        core_addr_t addr;
        logic       write;
        logic       sel;
        logic       enable;
        apb_data_t  wdata;
    } apb_req_t;

    typedef struct packed {
        apb_data_t rdata;
        logic      ready;
    } apb_rsp_t;

    // Low 28 bits of the command word, op in the top bits
    typedef struct packed {
        mdio_op_t   op;
        mdio_addr_t phy;
        mdio_addr_t regad;
        mdio_data_t data;
    } mdio_cmd_t;

    typedef struct packed {
        logic mdc;
        logic mdo;
        logic mdo_en;
    } mdio_pins_t;

    // Register map of one slice
    localparam reg_off_t  REG_ID        = 4'h0;
    localparam reg_off_t  REG_SCRATCH   = 4'h4;
    localparam reg_off_t  REG_MDIO_CMD  = 4'h8;
    localparam reg_off_t  REG_MDIO_STAT = 4'hC;
    localparam apb_data_t CORE_ID_BASE  = 32'h4D41_0000;

endpackage

// File: hdl/mdio_frame_tx.sv
/*
 * MDIO management frame transmitter for one core.
 * A start strobe latches a 64-bit frame (preamble, start, op, PHY and
 * register address, turnaround, data) and shifts it out MSB first with
 * MDC derived from pclk. mdo changes where MDC falls and mdi is sampled
 * where MDC rises. Read frames release mdo_en for the turnaround and data
 * bits and collect the PHY's data into rd_data.
 */
module mdio_frame_tx
    import mac_mgmt_pkg::*;
(
    input  logic       pclk,
    input  logic       reset,
    input  logic       start,
    input  mdio_cmd_t  cmd,
    input  logic       mdi,
    output logic       busy,
    output mdio_data_t rd_data,
    output mdio_pins_t pins
);

    mdio_state_t          state;
    logic [MDC_DIV_W-1:0] div_cnt;
    logic [BIT_CNT_W-1:0] bit_cnt;
    mdio_frame_t          frame_q;
    mdio_frame_t          next_frame;
    logic                 is_read_q;
    logic                 load;
    logic                 mdc_tick;
    logic                 mdc_rise;
    logic                 mdc_fall;

    // Turnaround and data of a read are driven by the PHY, fill with idle ones
    function automatic mdio_frame_t build_frame(input mdio_cmd_t c);
        logic [1:0] ta;
        mdio_data_t data;
        ta   = 2'b10;
        data = c.data;
        if (c.op == OP_READ) begin
            ta   = 2'b11;
            data = '1;
        end
        return {32'hFFFF_FFFF, 2'b01, c.op, c.phy, c.regad, ta, data};
    endfunction

    assign next_frame = build_frame(cmd);
    assign load       = start && (state != ST_SHIFT);
    assign busy       = (state == ST_SHIFT);

    assign mdc_tick = (div_cnt == MDC_HALF - 1);
    assign mdc_rise = busy && mdc_tick && !pins.mdc;
    assign mdc_fall = busy && mdc_tick && pins.mdc;

    ////////////////////
    // Control FSM
    ////////////////////
    always_ff @(posedge pclk) begin
        if (reset) begin
            state   <= ST_IDLE;
            div_cnt <= '0;
            bit_cnt <= '0;
            pins    <= '0;
            rd_data <= '0;
        end else begin
            case (state)
                ST_SHIFT: begin
                    div_cnt <= mdc_tick ? '0 : div_cnt + 1'b1;
                    if (mdc_rise) begin
                        pins.mdc <= 1'b1;
                        if (is_read_q && bit_cnt >= MDIO_DATA_POS) begin
                            rd_data <= {rd_data[MDIO_DATA_W-2:0], mdi};
                        end
                    end
                    if (mdc_fall) begin
                        pins.mdc <= 1'b0;
                        if (bit_cnt == FRAME_BITS - 1) begin
                            state       <= ST_DONE;
                            pins.mdo    <= 1'b0;
                            pins.mdo_en <= 1'b0;
                        end else begin
                            bit_cnt     <= bit_cnt + 1'b1;
                            pins.mdo    <= frame_q[FRAME_BITS-2];
                            // Hand the line to the PHY from the turnaround on
                            pins.mdo_en <= !(is_read_q && bit_cnt >= MDIO_TA_POS - 1);
                        end
                    end
                end
                default: begin
                    // Idle or just finished, a new frame may start right away
                    state   <= ST_IDLE;
                    div_cnt <= '0;
                    bit_cnt <= '0;
                    if (load) begin
                        state       <= ST_SHIFT;
                        pins.mdc    <= 1'b0;
                        pins.mdo    <= next_frame[FRAME_BITS-1];
                        pins.mdo_en <= 1'b1;
                    end
                end
            endcase
        end
    end

    ////////////////////
    // Frame shifter
    ////////////////////
    always_ff @(posedge pclk) begin
        if (load) begin
            frame_q   <= next_frame;
            is_read_q <= (cmd.op == OP_READ);
        end else if (mdc_fall) begin
            frame_q <= {frame_q[FRAME_BITS-2:0], 1'b0};
        end
    end

endmodule

// File: hdl/mac_core_regs.sv
/*
 * Register slice of one MAC core: identity, scratch, MDIO command and
 * MDIO status. A command write starts the local MDIO transmitter; while
 * a frame is still going out the write is held off with pready low.
 * CORE_INDEX sets the low bits of the identity word.
 */
module mac_core_regs
    import mac_mgmt_pkg::*;
#(
    parameter int unsigned CORE_INDEX = 0
) (
    input  logic       pclk,
    input  logic       reset,
    input  apb_req_t   req,
    input  logic       mdi,
    output apb_rsp_t   rsp,
    output mdio_pins_t pins
);

    logic       access;
    logic       in_range;
    reg_off_t   offset;
    logic       cmd_hit;
    logic       start;
    logic       busy;
    mdio_cmd_t  cmd_word;
    mdio_cmd_t  cmd_q;
    mdio_data_t rd_data;
    apb_data_t  scratch_q;
    apb_data_t  rd_word;

    ////////////////////
    // Address decode
    ////////////////////
    assign access = req.sel && req.enable;

    // Bit 18 is part of the core select for cores 1 to 3, so it is ignored here
    assign in_range = (req.addr[CORE_ADDR_W-2:4] == '0);
    assign offset   = {req.addr[3:2], 2'b00};
    assign cmd_hit  = in_range && (offset == REG_MDIO_CMD);

    assign cmd_word = mdio_cmd_t'(req.wdata[$bits(mdio_cmd_t)-1:0]);

    // Command write waits for the transmitter to go idle
    assign start     = access && req.write && cmd_hit && !busy;
    assign rsp.ready = access && !(req.write && cmd_hit && busy);

    ////////////////////
    // Writable registers
    ////////////////////
    always_ff @(posedge pclk) begin
        if (reset) begin
            scratch_q <= '0;
            cmd_q     <= '0;
        end else begin
            if (access && req.write && in_range && offset == REG_SCRATCH) begin
                scratch_q <= req.wdata;
            end
            // Last accepted command, for read-back
            if (start) begin
                cmd_q <= cmd_word;
            end
        end
    end

    ////////////////////
    // Read mux
    ////////////////////
    always_comb begin
        rd_word = '0;
        if (in_range) begin
            case (offset)
                REG_ID:        rd_word = CORE_ID_BASE + apb_data_t'(CORE_INDEX);
                REG_SCRATCH:   rd_word = scratch_q;
                REG_MDIO_CMD:  rd_word = {4'h0, cmd_q};
                REG_MDIO_STAT: rd_word = {rd_data, 15'd0, busy};
                default:       rd_word = '0;
            endcase
        end
    end

    // Zero unless this slice is in a read access
    assign rsp.rdata = (access && !req.write) ? rd_word : '0;

    mdio_frame_tx mdio_frame_tx_inst (
        .pclk    (pclk),
        .reset   (reset),
        .start   (start),
        .cmd     (cmd_word),
        .mdi     (mdi),
        .busy    (busy),
        .rd_data (rd_data),
        .pins    (pins)
    );

endmodule

// File: hdl/apb_bus_allocator.sv
/*
 * Host APB fan-out to the four MAC core register slices.
 * Address bit 18 low always selects core 0, otherwise bits 20:19 pick
 * the core. Only the selected slice sees sel, enable and write; address
 * and write data go to all. Responses come back through a mux and the
 * MDIO pin sets of all slices are merged by OR.
 */
module apb_bus_allocator
    import mac_mgmt_pkg::*;
(
    input  apb_addr_t  paddr,
    input  logic       pwrite,
    input  logic       psel,
    input  logic       penable,
    input  apb_data_t  pwdata,
    output apb_data_t  prdata,
    output logic       pready,
    output apb_req_t   core_req  [N_CORES],
    input  apb_rsp_t   core_rsp  [N_CORES],
    input  mdio_pins_t core_pins [N_CORES],
    output logic       mdc,
    output logic       mdo,
    output logic       mdo_en
);

    core_idx_t          core_idx;
    logic [N_CORES-1:0] core_hit;
    mdio_pins_t         merged;

    ////////////////////
    // Core decode
    ////////////////////
    always_comb begin
        if (!paddr[CORE_ADDR_W-1]) begin
            core_idx = '0;
        end else begin
            core_idx = paddr[APB_ADDR_W-1 -: CORE_SEL_W];
        end
    end

    // One-hot copy of the index for the gating below
    always_comb begin
        core_hit           = '0;
        core_hit[core_idx] = 1'b1;
    end

    ////////////////////
    // Request fan-out
    ////////////////////
    always_comb begin
        for (int i = 0; i < N_CORES; i++) begin
            core_req[i].addr   = paddr[CORE_ADDR_W-1:0];
            core_req[i].wdata  = pwdata;
            core_req[i].sel    = psel && core_hit[i];
            core_req[i].enable = penable && core_hit[i];
            core_req[i].write  = pwrite && core_hit[i];
        end
    end

    // Slices return zero data and no ready when they are not selected
    assign prdata = core_rsp[core_idx].rdata;
    assign pready = core_rsp[core_idx].ready;

    ////////////////////
    // MDIO pin merge
    ////////////////////
    // Idle transmitters hold all three pins low, so OR is enough
    always_comb begin
        merged = '0;
        for (int i = 0; i < N_CORES; i++) begin
            merged = merged | core_pins[i];
        end
    end

    assign mdc    = merged.mdc;
    assign mdo    = merged.mdo;
    assign mdo_en = merged.mdo_en;

endmodule

// File: hdl/mac_mgmt_top.sv
/*
 * Management block of a four-core Ethernet MAC cluster.
 * The host APB port is split by the allocator over four register
 * slices, each with its own MDIO transmitter. mdi from the PHY reaches
 * every slice and the merged MDIO pins leave the block.
 */
module mac_mgmt_top
    import mac_mgmt_pkg::*;
(
    input  logic      pclk,
    input  logic      reset,
    input  apb_addr_t paddr,
    input  logic      pwrite,
    input  logic      psel,
    input  logic      penable,
    input  apb_data_t pwdata,
    output apb_data_t prdata,
    output logic      pready,
    input  logic      mdi,
    output logic      mdc,
    output logic      mdo,
    output logic      mdo_en
);

    apb_req_t   core_req  [N_CORES];
    apb_rsp_t   core_rsp  [N_CORES];
    mdio_pins_t core_pins [N_CORES];

    apb_bus_allocator apb_bus_allocator_inst (
        .paddr     (paddr),
        .pwrite    (pwrite),
        .psel      (psel),
        .penable   (penable),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .core_req  (core_req),
        .core_rsp  (core_rsp),
        .core_pins (core_pins),
        .mdc       (mdc),
        .mdo       (mdo),
        .mdo_en    (mdo_en)
    );

    ////////////////////
    // Core slices
    ////////////////////
    genvar i;
    generate
        for (i = 0; i < N_CORES; i++) begin : g_core
            mac_core_regs #(
                .CORE_INDEX (i)
            ) mac_core_regs_inst (
                .pclk  (pclk),
                .reset (reset),
                .req   (core_req[i]),
                .mdi   (mdi),
                .rsp   (core_rsp[i]),
                .pins  (core_pins[i])
            );
        end
    endgenerate

endmodule

// File: sim/tb_clock_gen.sv
/*
 * Clock and reset source for the MAC management testbench.
 * pclk runs with a 10 ns period and reset is held high for the
 * first 16 rising edges, then released on an edge.
 */
module tb_clock_gen (
    output logic pclk,
    output logic reset
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int HALF_PERIOD  = 5;
    localparam int RESET_CYCLES = 16;

    initial begin
        pclk = 1'b0;
        forever #HALF_PERIOD pclk = ~pclk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge pclk);
        reset <= 1'b0;
    end

endmodule

// File: sim/mac_mgmt_assert.sv
/*
 * Protocol checks on the APB allocator, bound into every
 * apb_bus_allocator instance from the testbench top. Clock and reset
 * come from the testbench since the allocator is purely combinational.
 */
module mac_mgmt_assert
    import mac_mgmt_pkg::*;
(
    input logic       pclk,
    input logic       reset,
    input apb_addr_t  paddr,
    input logic       psel,
    input logic       penable,
    input logic       pready,
    input apb_data_t  prdata,
    input apb_req_t   core_req  [N_CORES],
    input mdio_pins_t core_pins [N_CORES]
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [N_CORES-1:0] sel_vec;
    logic [N_CORES-1:0] sel_exp;
    logic [N_CORES-1:0] drive_vec;

    always_comb begin
        for (int i = 0; i < N_CORES; i++) begin
            sel_vec[i]   = core_req[i].sel;
            drive_vec[i] = core_pins[i].mdo_en;
        end
    end

    // Bit 18 low means core 0, otherwise bits 20:19 name the core
    always_comb begin
        sel_exp = '0;
        if (psel) begin
            sel_exp[paddr[18] ? paddr[20:19] : 2'd0] = 1'b1;
        end
    end

    // Only the addressed slice sees sel
    sel_decode: assert property (@(posedge pclk) disable iff (reset) sel_vec == sel_exp)
        else $error("slice select %b, expected %b", sel_vec, sel_exp);

    ready_in_access: assert property (@(posedge pclk) disable iff (reset)
        pready |-> (psel && penable))
        else $error("pready high outside an APB access phase");

    idle_rdata_zero: assert property (@(posedge pclk) disable iff (reset)
        !psel |-> (prdata == '0))
        else $error("read data %h with no slice selected", prdata);

    // Only one frame on the wire at a time
    one_mdio_driver: assert property (@(posedge pclk) disable iff (reset) $onehot0(drive_vec))
        else $error("mdo_en driven by several slices: %b", drive_vec);

endmodule

// File: sim/tb_mac_mgmt.sv
/*
 * Directed testbench for the MAC cluster management block.
 * Drives the host APB port, watches the merged MDIO pins the way a PHY
 * would and answers read frames on mdi. Each test prints one result
 * line and a summary line closes the run.
 */
module tb_mac_mgmt
    import mac_mgmt_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int          WAIT_LIMIT   = 1000;
    localparam int          FRAME_CYCLES = FRAME_BITS * 2 * MDC_HALF;
    localparam apb_data_t   ID_BASE      = 32'h4D41_0000;
    // Bits the station drives in a read frame, ahead of the turnaround
    localparam mdio_frame_t HEAD_MASK    = {{46{1'b1}}, {18{1'b0}}};

    logic        pclk;
    logic        reset;
    apb_addr_t   paddr;
    logic        pwrite;
    logic        psel;
    logic        penable;
    apb_data_t   pwdata;
    apb_data_t   prdata;
    logic        pready;
    logic        mdi;
    logic        mdc;
    logic        mdo;
    logic        mdo_en;
    int unsigned cycle = 0;
    int unsigned last_done_cycle = 0;
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    int          errors_at_start = 0;

    tb_clock_gen tb_clock_gen_inst (
        .pclk  (pclk),
        .reset (reset)
    );

    mac_mgmt_top mac_mgmt_top_inst (
        .pclk    (pclk),
        .reset   (reset),
        .paddr   (paddr),
        .pwrite  (pwrite),
        .psel    (psel),
        .penable (penable),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .mdi     (mdi),
        .mdc     (mdc),
        .mdo     (mdo),
        .mdo_en  (mdo_en)
    );

    bind apb_bus_allocator mac_mgmt_assert mac_mgmt_assert_inst (
        .pclk      (tb_mac_mgmt.pclk),
        .reset     (tb_mac_mgmt.reset),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pready    (pready),
        .prdata    (prdata),
        .core_req  (core_req),
        .core_pins (core_pins)
    );

    always @(posedge pclk) begin
        cycle <= cycle + 1;
    end

    ////////////////////
    // Compare tasks
    ////////////////////
    task automatic check_data(input string name, input apb_data_t exp, input apb_data_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error [%s] expected %h, got %h", name, exp, act);
        end
    endtask

    task automatic check_mdio(input string name, input mdio_data_t exp, input mdio_data_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error [%s] expected %h, got %h", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error [%s] expected %b, got %b", name, exp, act);
        end
    endtask

    task automatic check_frame(input string name, input mdio_frame_t exp, input mdio_frame_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error [%s] expected %h, got %h", name, exp, act);
        end
    endtask

    task automatic note_failure(input string what);
        errors++;
        $display("%s", what);
    endtask

    task automatic start_test();
        tests++;
        errors_at_start = errors;
    endtask

    task automatic end_test(input string name);
        $display("Test %-20s %s, %0d errors", name,
                 (errors == errors_at_start) ? "passed" : "failed", errors - errors_at_start);
    endtask

    ////////////////////
    // Address and frame rules
    ////////////////////
    // Core 0 sits below bit 18, the others are picked by bits 20:19
    function automatic apb_addr_t core_addr(input int core, input reg_off_t off);
        if (core == 0) begin
            return apb_addr_t'(off);
        end
        return {core_idx_t'(core), 1'b1, 14'd0, off};
    endfunction

    function automatic apb_data_t cmd_word(input mdio_op_t op, input mdio_addr_t phy,
                                           input mdio_addr_t regad, input mdio_data_t data);
        return {4'h0, op, phy, regad, data};
    endfunction

    // Write frame layout; for reads only the head above HEAD_MASK applies
    function automatic mdio_frame_t frame_of_command(input mdio_op_t op, input mdio_addr_t phy,
                                                     input mdio_addr_t regad,
                                                     input mdio_data_t data);
        return {32'hFFFF_FFFF, 2'b01, op, phy, regad, 2'b10, data};
    endfunction

    ////////////////////
    // APB host
    ////////////////////
    task automatic apb_transfer(input logic write, input apb_addr_t addr, input apb_data_t wdata,
                                output apb_data_t rdata);
        int n;
        @(posedge pclk);
        paddr   <= addr;
        pwrite  <= write;
        psel    <= 1'b1;
        penable <= 1'b0;
        pwdata  <= wdata;
        @(posedge pclk);
        penable <= 1'b1;
        n = 0;
        do begin
            @(posedge pclk);
            n++;
        end while (!pready && n < WAIT_LIMIT);
        if (!pready) begin
            note_failure($sformatf("APB access to %h saw no pready in %0d cycles",
                                   addr, WAIT_LIMIT));
        end
        rdata           = prdata;
        last_done_cycle = cycle;
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
        apb_data_t ignored;
        apb_transfer(1'b1, addr, data, ignored);
    endtask

    task automatic apb_read(input apb_addr_t addr, output apb_data_t data);
        apb_transfer(1'b0, addr, '0, data);
    endtask

    task automatic wait_idle(input int core, output apb_data_t stat);
        int n;
        n    = 0;
        stat = 32'h1;
        while (stat[0] && n < WAIT_LIMIT) begin
            apb_read(core_addr(core, REG_MDIO_STAT), stat);
            n++;
        end
        if (stat[0]) begin
            note_failure($sformatf("core %0d stayed busy after %0d status reads", core, n));
        end
    endtask

    ////////////////////
    // PHY-side monitor
    ////////////////////
    task automatic wait_mdc_rise(output bit ok);
        logic prev;
        int   n;
        prev = mdc;
        ok   = 1'b0;
        for (n = 0; n < WAIT_LIMIT && !ok; n++) begin
            @(posedge pclk);
            ok   = mdc && !prev;
            prev = mdc;
        end
    endtask

    task automatic capture_frame(input mdio_data_t phy_data, output mdio_frame_t bits,
                                 output mdio_frame_t en);
        bit ok;
        int k;
        bits = '0;
        en   = '0;
        for (k = 0; k < FRAME_BITS; k++) begin
            wait_mdc_rise(ok);
            if (!ok) begin
                note_failure($sformatf("MDC stopped before frame bit %0d", k));
                return;
            end
            bits[FRAME_BITS-1-k] = mdo;
            en[FRAME_BITS-1-k]   = mdo_en;
            // PHY presents the next data bit after this rising edge
            if (k >= MDIO_DATA_POS - 1 && k < FRAME_BITS - 1) begin
                mdi <= phy_data[MDIO_DATA_POS + MDIO_DATA_W - 2 - k];
            end else begin
                mdi <= 1'b0;
            end
        end
    endtask

    ////////////////////
    // Tests
    ////////////////////
    task automatic reset_state();
        apb_data_t rd;
        int        c;
        start_test();
        check_bit("reset pready", 1'b0, pready);
        check_bit("reset mdc", 1'b0, mdc);
        check_bit("reset mdo", 1'b0, mdo);
        check_bit("reset mdo_en", 1'b0, mdo_en);
        for (c = 0; c < N_CORES; c++) begin
            apb_read(core_addr(c, REG_MDIO_STAT), rd);
            check_bit($sformatf("core %0d busy", c), 1'b0, rd[0]);
            apb_read(core_addr(c, REG_SCRATCH), rd);
            check_data($sformatf("core %0d scratch", c), '0, rd);
        end
        end_test("reset_state");
    endtask

    task automatic address_decode();
        apb_data_t rd;
        int        c;
        start_test();
        for (c = 0; c < N_CORES; c++) begin
            apb_read(core_addr(c, REG_ID), rd);
            check_data($sformatf("core %0d id", c), ID_BASE + apb_data_t'(c), rd);
        end
        // Bit 18 low wins over the core bits
        apb_read({2'b11, 1'b0, 18'h0}, rd);
        check_data("alias to core 0", ID_BASE, rd);
        apb_read({2'b10, 1'b1, 18'h10}, rd);
        check_data("offset past status", '0, rd);
        end_test("address_decode");
    endtask

    task automatic scratch_isolation();
        apb_data_t vals [N_CORES];
        apb_data_t rd;
        int        c;
        start_test();
        for (c = 0; c < N_CORES; c++) begin
            vals[c] = $urandom;
            apb_write(core_addr(c, REG_SCRATCH), vals[c]);
        end
        for (c = 0; c < N_CORES; c++) begin
            apb_read(core_addr(c, REG_SCRATCH), rd);
            check_data($sformatf("core %0d scratch", c), vals[c], rd);
        end
        end_test("scratch_isolation");
    endtask

    task automatic mdio_write_frames();
        mdio_addr_t  phy;
        mdio_addr_t  regad;
        mdio_data_t  data;
        mdio_frame_t bits;
        mdio_frame_t en;
        apb_data_t   stat;
        int          c;
        start_test();
        for (c = 0; c < N_CORES; c++) begin
            phy   = mdio_addr_t'($urandom);
            regad = mdio_addr_t'($urandom);
            data  = mdio_data_t'($urandom);
            apb_write(core_addr(c, REG_MDIO_CMD), cmd_word(OP_WRITE, phy, regad, data));
            capture_frame('0, bits, en);
            check_frame($sformatf("core %0d write frame", c),
                        frame_of_command(OP_WRITE, phy, regad, data), bits);
            check_frame($sformatf("core %0d write mdo_en", c), '1, en);
            wait_idle(c, stat);
            // Busy must stay low once the frame is out
            apb_read(core_addr(c, REG_MDIO_STAT), stat);
            check_bit($sformatf("core %0d busy after write", c), 1'b0, stat[0]);
        end
        end_test("mdio_write_frames");
    endtask

    task automatic mdio_read_frames();
        mdio_addr_t  phy;
        mdio_addr_t  regad;
        mdio_data_t  phy_data;
        mdio_frame_t bits;
        mdio_frame_t en;
        apb_data_t   stat;
        int          c;
        start_test();
        for (c = 0; c < N_CORES; c++) begin
            phy      = mdio_addr_t'($urandom);
            regad    = mdio_addr_t'($urandom);
            phy_data = mdio_data_t'($urandom);
            apb_write(core_addr(c, REG_MDIO_CMD), cmd_word(OP_READ, phy, regad, '0));
            capture_frame(phy_data, bits, en);
            check_frame($sformatf("core %0d read head", c),
                        frame_of_command(OP_READ, phy, regad, '0) & HEAD_MASK, bits & HEAD_MASK);
            check_frame($sformatf("core %0d read mdo_en", c), HEAD_MASK, en);
            wait_idle(c, stat);
            check_mdio($sformatf("core %0d read data", c), phy_data, stat[31:16]);
        end
        end_test("mdio_read_frames");
    endtask

    task automatic command_back_pressure();
        mdio_addr_t  phy;
        mdio_addr_t  regad_a;
        mdio_addr_t  regad_b;
        mdio_data_t  data_a;
        mdio_data_t  data_b;
        mdio_frame_t bits_a;
        mdio_frame_t bits_b;
        mdio_frame_t en_a;
        mdio_frame_t en_b;
        apb_data_t   stat;
        int unsigned first_done;
        int unsigned second_done;
        start_test();
        phy     = mdio_addr_t'($urandom);
        regad_a = mdio_addr_t'($urandom);
        regad_b = mdio_addr_t'($urandom);
        data_a  = mdio_data_t'($urandom);
        data_b  = mdio_data_t'($urandom);
        apb_write(core_addr(1, REG_MDIO_CMD), cmd_word(OP_WRITE, phy, regad_a, data_a));
        first_done = last_done_cycle;
        fork
            begin
                capture_frame('0, bits_a, en_a);
                capture_frame('0, bits_b, en_b);
            end
            apb_write(core_addr(1, REG_MDIO_CMD), cmd_word(OP_WRITE, phy, regad_b, data_b));
        join
        second_done = last_done_cycle;
        // Busy clears after the full frame and the held write lands one cycle later
        if (second_done - first_done <= FRAME_CYCLES) begin
            note_failure($sformatf("second command accepted %0d cycles after the first",
                                   second_done - first_done));
        end
        check_frame("first frame", frame_of_command(OP_WRITE, phy, regad_a, data_a), bits_a);
        check_frame("first mdo_en", '1, en_a);
        check_frame("second frame", frame_of_command(OP_WRITE, phy, regad_b, data_b), bits_b);
        check_frame("second mdo_en", '1, en_b);
        wait_idle(1, stat);
        apb_read(core_addr(1, REG_MDIO_STAT), stat);
        check_bit("busy after both frames", 1'b0, stat[0]);
        end_test("command_back_pressure");
    endtask

    ////////////////////
    // Main sequence
    ////////////////////
    initial begin
        int n;
        paddr   = '0;
        pwrite  = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwdata  = '0;
        mdi     = 1'b0;
        void'($urandom(32'hae3c_35e7));
        n = 0;
        while (reset !== 1'b0 && n < WAIT_LIMIT) begin
            @(posedge pclk);
            n++;
        end
        if (reset !== 1'b0) begin
            note_failure("reset was never released");
        end
        reset_state();
        address_decode();
        scratch_isolation();
        mdio_write_frames();
        mdio_read_frames();
        command_back_pressure();
        $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: sources.f
hdl/mac_mgmt_pkg.sv
hdl/mdio_frame_tx.sv
hdl/mac_core_regs.sv
hdl/apb_bus_allocator.sv
hdl/mac_mgmt_top.sv
sim/tb_clock_gen.sv
sim/mac_mgmt_assert.sv
sim/tb_mac_mgmt.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the MAC management testbench with Verilator.
# Exits non-zero when the build fails, the simulation aborts or the
# testbench reports errors.
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --timescale 1ns/100ps \
    --top-module tb_mac_mgmt \
    -f sources.f \
    -o sim_tb_mac_mgmt

./obj_dir/sim_tb_mac_mgmt 2>&1 | tee "$LOG"

if grep -q "Done: errors found" "$LOG"; then
    echo "Simulation failed, see $LOG"
    exit 1
fi

echo "Simulation passed"
